// File: Makefile
VERILATOR  ?= verilator
TOP        ?= adc_link_tb
RTL_TOP    ?= adc_link_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the exact pass line shows up in the output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hdl/adc_link_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/sample_scheduler.sv
hdl/adc_spi_reader.sv
hdl/frame_packer.sv
hdl/adc_link_top.sv
verif/adc_link_tb.sv

// File: hdl/adc_link_pkg.sv
package adc_link_pkg;

    // Simulation-scale timing, raise for a real board clock

    // Clock cycles per UART bit
    localparam int baud_div = 16;

    // Clock cycles per half period of the converter serial clock
    localparam int sclk_half = 2;

    // Clock cycles between periodic sample ticks
    localparam int sample_period = 2000;

    // Converter word format
    localparam int sample_bits = 12;
    // Four leading zeros then twelve data bits, MSB first
    localparam int frame_bits = 16;

    // Command bytes received on the UART
    localparam logic [7:0] cmd_single = 8'h53;
    localparam logic [7:0] cmd_periodic = 8'h50;
    localparam logic [7:0] cmd_halt = 8'h48;

    // Outgoing frame
    localparam logic [7:0] frame_sync = 8'hA5;
    localparam int frame_len = 5;

endpackage

// File: hdl/adc_link_top.sv
`timescale 1ns/1ps

module adc_link_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    input  logic sdo_1,
    input  logic sdo_2,
    output logic tx,
    output logic cs_1,
    output logic sclk_1,
    output logic cs_2,
    output logic sclk_2
);

    // Command path
    logic [7:0] byte_data;
    logic       byte_valid;

    // Start and results
    logic sample_start;
    logic busy;
    logic [adc_link_pkg::sample_bits-1:0] value_1;
    logic [adc_link_pkg::sample_bits-1:0] value_2;
    logic done_1;
    logic done_2;

    // Transmit path
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    uart_rx u_uart_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    sample_scheduler u_scheduler (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .busy         (busy),
        .sample_start (sample_start)
    );

    // Both converters share the start pulse
    adc_spi_reader reader_1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .sdo          (sdo_1),
        .cs           (cs_1),
        .sclk         (sclk_1),
        .value        (value_1),
        .done         (done_1)
    );

    adc_spi_reader reader_2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .sdo          (sdo_2),
        .cs           (cs_2),
        .sclk         (sclk_2),
        .value        (value_2),
        .done         (done_2)
    );

    frame_packer u_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .value_1      (value_1),
        .done_1       (done_1),
        .value_2      (value_2),
        .done_2       (done_2),
        .tx_busy      (tx_busy),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .busy         (busy)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// File: hdl/adc_spi_reader.sv
`timescale 1ns/1ps

module adc_spi_reader (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 sample_start,
    input  logic                                 sdo,
    output logic                                 cs,
    output logic                                 sclk,
    output logic [adc_link_pkg::sample_bits-1:0] value,
    output logic                                 done
);

    localparam int half_w = $clog2(adc_link_pkg::sclk_half + 1);
    localparam int edges = 2 * adc_link_pkg::frame_bits;
    localparam int edge_w = $clog2(edges + 1);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_SHIFT,
        RD_END
    } rd_state_t;

    rd_state_t state;
    logic [half_w-1:0] half_cnt;
    logic [edge_w-1:0] edge_cnt;
    logic [adc_link_pkg::sample_bits-1:0] shift_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RD_IDLE;
            cs       <= 1'b1;
            sclk     <= 1'b1;
            done     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (sample_start) begin
                        cs       <= 1'b0;
                        half_cnt <= '0;
                        edge_cnt <= '0;
                        state    <= RD_SHIFT;
                    end
                end
                RD_SHIFT: begin
                    if (half_cnt == half_w'(adc_link_pkg::sclk_half - 1)) begin
                        half_cnt <= '0;
                        sclk     <= ~sclk;
                        edge_cnt <= edge_cnt + 1'b1;
                        // Sample on the rising edge, data moved on the falling one
                        if (!sclk) begin
                            shift_reg <= {shift_reg[adc_link_pkg::sample_bits-2:0], sdo};
                        end
                        if (edge_cnt == edge_w'(edges - 1)) begin
                            cs    <= 1'b1;
                            state <= RD_END;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                RD_END: begin
                    // Leading zeros fall off the top
                    value <= shift_reg;
                    done  <= 1'b1;
                    state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/frame_packer.sv
`timescale 1ns/1ps

module frame_packer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 sample_start,
    input  logic [adc_link_pkg::sample_bits-1:0] value_1,
    input  logic                                 done_1,
    input  logic [adc_link_pkg::sample_bits-1:0] value_2,
    input  logic                                 done_2,
    input  logic                                 tx_busy,
    output logic [7:0]                           tx_data,
    output logic                                 tx_start,
    output logic                                 busy
);

    localparam int idx_w = $clog2(adc_link_pkg::frame_len);

    typedef enum logic [1:0] {
        FP_IDLE,
        FP_COLLECT,
        FP_SEND,
        FP_DRAIN
    } fp_state_t;

    fp_state_t state;
    logic [adc_link_pkg::sample_bits-1:0] ch_1;
    logic [adc_link_pkg::sample_bits-1:0] ch_2;
    logic       have_1;
    logic       have_2;
    logic [idx_w-1:0] idx;
    logic [7:0] byte_1;
    logic [7:0] byte_2;
    logic [7:0] byte_3;
    logic [7:0] checksum;
    logic [7:0] cur_byte;
    logic       tx_free;

    // Payload packing, nibbles of ch_1 low bits and ch_2 high bits share byte 2
    assign byte_1   = ch_1[11:4];
    assign byte_2   = {ch_1[3:0], ch_2[11:8]};
    assign byte_3   = ch_2[7:0];
    assign checksum = byte_1 ^ byte_2 ^ byte_3;

    always_comb begin
        case (idx)
            idx_w'(0): cur_byte = adc_link_pkg::frame_sync;
            idx_w'(1): cur_byte = byte_1;
            idx_w'(2): cur_byte = byte_2;
            idx_w'(3): cur_byte = byte_3;
            default:   cur_byte = checksum;
        endcase
    end

    // Busy from the transmitter lags the strobe by one cycle
    assign tx_free = !tx_busy && !tx_start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= FP_IDLE;
            have_1   <= 1'b0;
            have_2   <= 1'b0;
            idx      <= '0;
            tx_start <= 1'b0;
            busy     <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                FP_IDLE: begin
                    if (sample_start) begin
                        have_1 <= 1'b0;
                        have_2 <= 1'b0;
                        busy   <= 1'b1;
                        state  <= FP_COLLECT;
                    end
                end
                FP_COLLECT: begin
                    if (done_1) begin
                        ch_1   <= value_1;
                        have_1 <= 1'b1;
                    end
                    if (done_2) begin
                        ch_2   <= value_2;
                        have_2 <= 1'b1;
                    end
                    if (have_1 && have_2) begin
                        idx   <= '0;
                        state <= FP_SEND;
                    end
                end
                FP_SEND: begin
                    if (tx_free) begin
                        tx_data  <= cur_byte;
                        tx_start <= 1'b1;
                        if (idx == idx_w'(adc_link_pkg::frame_len - 1)) begin
                            state <= FP_DRAIN;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                // Hold busy through the last stop bit
                FP_DRAIN: begin
                    if (tx_free) begin
                        busy  <= 1'b0;
                        state <= FP_IDLE;
                    end
                end
                default: state <= FP_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/sample_scheduler.sv
`timescale 1ns/1ps

module sample_scheduler (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    input  logic       busy,
    output logic       sample_start
);

    localparam int tick_w = $clog2(adc_link_pkg::sample_period);

    logic [tick_w-1:0] tick_cnt;
    logic              tick;
    logic              periodic_en;
    logic              single_req;
    logic              periodic_req;

    assign tick         = (tick_cnt == tick_w'(adc_link_pkg::sample_period - 1));
    assign single_req   = byte_valid && (byte_data == adc_link_pkg::cmd_single);
    assign periodic_req = tick && periodic_en;

    // Free-running period timer
    always_ff @(posedge clk) begin
        if (!rst_n || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Mode commands apply even during a frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            periodic_en <= 1'b0;
        end else if (byte_valid) begin
            if (byte_data == adc_link_pkg::cmd_periodic) begin
                periodic_en <= 1'b1;
            end else if (byte_data == adc_link_pkg::cmd_halt) begin
                periodic_en <= 1'b0;
            end
        end
    end

    // Busy rises one cycle after the pulse, so block back-to-back starts too
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_start <= 1'b0;
        end else begin
            sample_start <= (single_req || periodic_req) && !busy && !sample_start;
        end
    end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    localparam int cnt_w = $clog2(adc_link_pkg::baud_div);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_WAIT_HIGH
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                // Wait half a bit to land in the middle of the start bit
                RX_START: begin
                    if (baud_cnt == cnt_w'(adc_link_pkg::baud_div / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // A short glitch is not a start bit
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == cnt_w'(adc_link_pkg::baud_div - 1)) begin
                        baud_cnt  <= '0;
                        // LSB arrives first
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == cnt_w'(adc_link_pkg::baud_div - 1)) begin
                        baud_cnt <= '0;
                        if (rx_sync) begin
                            byte_data  <= shift_reg;
                            byte_valid <= 1'b1;
                            state      <= RX_IDLE;
                        end else begin
                            // Framing error, drop the byte
                            state <= RX_WAIT_HIGH;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_WAIT_HIGH: begin
                    if (rx_sync) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);

    localparam int cnt_w = $clog2(adc_link_pkg::baud_div);

    logic [9:0]       shift_reg;
    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;

    // Line follows the low end of the shift register
    assign tx = shift_reg[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_reg <= '1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            tx_busy   <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Stop bit, data LSB first, start bit
                shift_reg <= {1'b1, tx_data, 1'b0};
                baud_cnt  <= '0;
                bit_cnt   <= '0;
                tx_busy   <= 1'b1;
            end
        end else begin
            if (baud_cnt == cnt_w'(adc_link_pkg::baud_div - 1)) begin
                baud_cnt  <= '0;
                // Shift in ones so the line rests high afterwards
                shift_reg <= {1'b1, shift_reg[9:1]};
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verif/adc_link_tb.sv
`timescale 1ns/1ps

module adc_link_tb;

    localparam int start_timeout = adc_link_pkg::sample_period + 500;
    localparam int idle_cycles = 12 * adc_link_pkg::baud_div;
    localparam int idle_timeout = 3 * adc_link_pkg::sample_period;
    localparam int watchdog_cycles = 100000;

    logic clk = 1'b0;
    logic rst_n;
    logic rx;
    logic sdo_1 = 1'b0;
    logic sdo_2 = 1'b0;
    logic tx;
    logic cs_1;
    logic sclk_1;
    logic cs_2;
    logic sclk_2;

    // Converter model state
    logic [11:0] adc_val_1;
    logic [11:0] adc_val_2;
    logic [15:0] adc_shift_1;
    logic [15:0] adc_shift_2;

    logic [7:0] rx_frame [adc_link_pkg::frame_len];
    logic [7:0] exp_frame [adc_link_pkg::frame_len];
    bit got_frame;

    int seed;
    int mismatch_count;
    int timeout_count;
    int error_count;

    adc_link_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx     (rx),
        .sdo_1  (sdo_1),
        .sdo_2  (sdo_2),
        .tx     (tx),
        .cs_1   (cs_1),
        .sclk_1 (sclk_1),
        .cs_2   (cs_2),
        .sclk_2 (sclk_2)
    );

    always #50 clk = ~clk;

    // Four zeros then the value, MSB first, moved on falling sclk
    always @(negedge cs_1 or negedge sclk_1) begin
        if (cs_1 === 1'b0) begin
            if (sclk_1 === 1'b1) begin
                adc_shift_1 = {4'h0, adc_val_1};
            end else begin
                #1;
                sdo_1 = adc_shift_1[15];
                adc_shift_1 = {adc_shift_1[14:0], 1'b0};
            end
        end
    end

    always @(negedge cs_2 or negedge sclk_2) begin
        if (cs_2 === 1'b0) begin
            if (sclk_2 === 1'b1) begin
                adc_shift_2 = {4'h0, adc_val_2};
            end else begin
                #1;
                sdo_2 = adc_shift_2[15];
                adc_shift_2 = {adc_shift_2[14:0], 1'b0};
            end
        end
    end

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_sample(input string name,
                                input logic [adc_link_pkg::sample_bits-1:0] expected,
                                input logic [adc_link_pkg::sample_bits-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %03h, actual %03h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // 8N1, start bit first, data LSB first
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, data, 1'b0};
        @(posedge clk);
        #1;
        for (int b = 0; b < 10; b++) begin
            rx = bits[b];
            repeat (adc_link_pkg::baud_div) @(posedge clk);
            #1;
        end
        rx = 1'b1;
        repeat (adc_link_pkg::baud_div) @(posedge clk);
        #1;
    endtask

    // Samples on the falling clock edge, away from DUT updates
    task automatic receive_byte(input string name, output logic [7:0] data, output bit ok);
        int wait_cnt;
        wait_cnt = 0;
        data = 8'h00;
        ok = 1'b0;
        while (tx !== 1'b0 && wait_cnt < start_timeout) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (tx !== 1'b0) begin
            $display("%s: no start bit on tx within %0d cycles", name, start_timeout);
            timeout_count++;
            return;
        end
        repeat (adc_link_pkg::baud_div / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            $display("%s: start bit on tx was too short", name);
            error_count++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (adc_link_pkg::baud_div) @(negedge clk);
            data[i] = tx;
        end
        repeat (adc_link_pkg::baud_div) @(negedge clk);
        if (tx !== 1'b1) begin
            $display("%s: stop bit on tx was low", name);
            error_count++;
        end
        ok = 1'b1;
    endtask

    task automatic receive_frame(input string name);
        bit ok;
        got_frame = 1'b1;
        for (int i = 0; i < adc_link_pkg::frame_len; i++) begin
            receive_byte($sformatf("%s byte %0d", name, i), rx_frame[i], ok);
            if (!ok) begin
                got_frame = 1'b0;
                return;
            end
        end
    endtask

    // Expected frame from the layout rules: sync, packed payload, XOR
    task automatic check_frame(input string name, input logic [11:0] v1,
                               input logic [11:0] v2);
        exp_frame[0] = adc_link_pkg::frame_sync;
        exp_frame[1] = v1[11:4];
        exp_frame[2] = {v1[3:0], v2[11:8]};
        exp_frame[3] = v2[7:0];
        exp_frame[4] = exp_frame[1] ^ exp_frame[2] ^ exp_frame[3];
        if (!got_frame) begin
            return;
        end
        for (int i = 0; i < adc_link_pkg::frame_len; i++) begin
            check_byte($sformatf("%s byte %0d", name, i), exp_frame[i], rx_frame[i]);
        end
        check_sample({name, " ch1"}, v1, {rx_frame[1], rx_frame[2][7:4]});
        check_sample({name, " ch2"}, v2, {rx_frame[2][3:0], rx_frame[3]});
    endtask

    task automatic expect_silence(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (tx !== 1'b1 || cs_1 !== 1'b1 || cs_2 !== 1'b1 ||
                sclk_1 !== 1'b1 || sclk_2 !== 1'b1) begin
                $display("%s: tx, a chip select or a serial clock left idle at cycle %0d",
                         name, i);
                error_count++;
                return;
            end
        end
    endtask

    // Lets a frame in progress drain before checking for quiet
    task automatic wait_line_idle(input string name);
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < idle_cycles && waited < idle_timeout) begin
            @(negedge clk);
            waited++;
            if (tx === 1'b1 && cs_1 === 1'b1 && cs_2 === 1'b1) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < idle_cycles) begin
            $display("%s: link did not go idle within %0d cycles", name, idle_timeout);
            timeout_count++;
        end
    endtask

    task automatic pick_random_values();
        logic [31:0] rnd;
        rnd = $random(seed);
        adc_val_1 = rnd[11:0];
        adc_val_2 = rnd[27:16];
    endtask

    task automatic single_sample(input string name, input logic [11:0] v1,
                                 input logic [11:0] v2);
        adc_val_1 = v1;
        adc_val_2 = v2;
        send_byte(adc_link_pkg::cmd_single, 1'b0);
        receive_frame(name);
        check_frame(name, v1, v2);
    endtask

    task automatic test_reset_idle();
        expect_silence("reset idle", 3 * adc_link_pkg::sample_period);
    endtask

    task automatic test_single_basic();
        single_sample("single basic", 12'h123, 12'hABC);
    endtask

    task automatic test_single_extremes();
        single_sample("single fff 000", 12'hFFF, 12'h000);
        single_sample("single 000 fff", 12'h000, 12'hFFF);
    endtask

    task automatic test_periodic_halt();
        logic [11:0] v1;
        logic [11:0] v2;
        string name;
        pick_random_values();
        send_byte(adc_link_pkg::cmd_periodic, 1'b0);
        for (int k = 0; k < 3; k++) begin
            v1 = adc_val_1;
            v2 = adc_val_2;
            name = $sformatf("periodic frame %0d", k);
            receive_frame(name);
            check_frame(name, v1, v2);
            // Next tick is far off, safe to change the converters now
            pick_random_values();
        end
        send_byte(adc_link_pkg::cmd_halt, 1'b0);
        wait_line_idle("halt");
        expect_silence("after halt", 3 * adc_link_pkg::sample_period);
    endtask

    task automatic test_rejected_commands();
        send_byte(8'h3C, 1'b0);
        expect_silence("unknown command", 20 * adc_link_pkg::baud_div);
        send_byte(adc_link_pkg::cmd_single, 1'b1);
        expect_silence("bad stop bit", 20 * adc_link_pkg::baud_div);
        single_sample("single after rejects", 12'h5A7, 12'h3C9);
    endtask

    initial begin
        seed = 30418;
        mismatch_count = 0;
        timeout_count = 0;
        error_count = 0;
        adc_val_1 = 12'h000;
        adc_val_2 = 12'h000;
        rx = 1'b1;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_idle();
        test_single_basic();
        test_single_extremes();
        test_periodic_halt();
        test_rejected_commands();

        $display("Checks done: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatch_count, timeout_count, error_count);
        if (mismatch_count == 0 && timeout_count == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Hard stop in case a test never returns
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule
